/* design/axi_pkg.sv */
// AXI read channel field widths and response and burst encodings
package axi_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int LEN_W  = 4;
  localparam int SIZE_W = 3;

  localparam int ID_W  = 4;
  // Slave side carries one extra bit for the master index
  localparam int IDS_W = ID_W + 1;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

endpackage

/* design/xbar_pkg.sv */
// Interconnect size, fixed slave address map and master port FSM states
package xbar_pkg;

  localparam int N_MST     = 2;
  localparam int N_SLV     = 2;
  localparam int SLV_SEL_W = N_SLV;

  // One 64 KiB region per slave
  localparam logic [31:0] S0_BASE  = 32'h0000_0000;
  localparam logic [31:0] S1_BASE  = 32'h0001_0000;
  localparam logic [31:0] SLV_SPAN = 32'h0001_0000;

  typedef enum logic [1:0] {
    MST_IDLE   = 2'd0,
    MST_REQ    = 2'd1,
    MST_DATA   = 2'd2,
    MST_DECERR = 2'd3
  } mst_state_e;

endpackage

/* design/rd_master_port.sv */
// Master side read port that accepts and decodes one AR and returns its R beats
`timescale 1ns/100ps

module rd_master_port (
  input  logic                           axi_clk_i,
  input  logic                           rst_n_i,
  // AR from the master
  input  logic [axi_pkg::ID_W-1:0]       ar_id_i,
  input  logic [axi_pkg::ADDR_W-1:0]     ar_addr_i,
  input  logic [axi_pkg::LEN_W-1:0]      ar_len_i,
  input  logic [axi_pkg::SIZE_W-1:0]     ar_size_i,
  input  axi_pkg::axi_burst_e            ar_burst_i,
  input  logic                           ar_valid_i,
  output logic                           ar_ready_o,
  // R to the master
  output logic [axi_pkg::ID_W-1:0]       r_id_o,
  output logic [axi_pkg::DATA_W-1:0]     r_data_o,
  output axi_pkg::axi_resp_e             r_resp_o,
  output logic                           r_last_o,
  output logic                           r_valid_o,
  input  logic                           r_ready_i,
  // Request and held AR toward the slave ports
  output logic [xbar_pkg::SLV_SEL_W-1:0] req_o,
  input  logic [xbar_pkg::SLV_SEL_W-1:0] grant_done_i,
  output logic [axi_pkg::ID_W-1:0]       hold_id_o,
  output logic [axi_pkg::ADDR_W-1:0]     hold_addr_o,
  output logic [axi_pkg::LEN_W-1:0]      hold_len_o,
  output logic [axi_pkg::SIZE_W-1:0]     hold_size_o,
  output axi_pkg::axi_burst_e            hold_burst_o,
  // R beats steered here by each slave port
  input  logic [axi_pkg::ID_W-1:0]       sl_r_id_i   [xbar_pkg::N_SLV],
  input  logic [axi_pkg::DATA_W-1:0]     sl_r_data_i [xbar_pkg::N_SLV],
  input  axi_pkg::axi_resp_e             sl_r_resp_i [xbar_pkg::N_SLV],
  input  logic [xbar_pkg::N_SLV-1:0]     sl_r_last_i,
  input  logic [xbar_pkg::N_SLV-1:0]     sl_r_valid_i
);

  import axi_pkg::*;
  import xbar_pkg::*;

  mst_state_e           state_q;
  mst_state_e           state_d;
  logic [SLV_SEL_W-1:0] dec_sel;
  logic [SLV_SEL_W-1:0] tgt_q;
  logic                 ar_hs;
  logic                 r_hs;

  logic [ID_W-1:0]      id_q;
  logic [ADDR_W-1:0]    addr_q;
  logic [LEN_W-1:0]     len_q;
  logic [SIZE_W-1:0]    size_q;
  axi_burst_e           burst_q;

  assign ar_ready_o = (state_q == MST_IDLE);
  assign ar_hs      = ar_valid_i && ar_ready_o;
  assign r_hs       = r_valid_o && r_ready_i;

  // Address map decode, regions never overlap so at most one bit is set
  assign dec_sel[0] = (ar_addr_i - S0_BASE) < SLV_SPAN;
  assign dec_sel[1] = (ar_addr_i - S1_BASE) < SLV_SPAN;

  always_ff @(posedge axi_clk_i) begin
    if (!rst_n_i) begin
      state_q <= MST_IDLE;
      tgt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (ar_hs) begin
        tgt_q <= dec_sel;
      end
    end
  end

  // Accepted AR
  always_ff @(posedge axi_clk_i) begin
    if (ar_hs) begin
      id_q    <= ar_id_i;
      addr_q  <= ar_addr_i;
      len_q   <= ar_len_i;
      size_q  <= ar_size_i;
      burst_q <= ar_burst_i;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      MST_IDLE: begin
        if (ar_hs) begin
          state_d = (|dec_sel) ? MST_REQ : MST_DECERR;
        end
      end
      MST_REQ: begin
        if (|(grant_done_i & tgt_q)) begin
          state_d = MST_DATA;
        end
      end
      MST_DATA, MST_DECERR: begin
        if (r_hs && r_last_o) begin
          state_d = MST_IDLE;
        end
      end
      default: state_d = MST_IDLE;
    endcase
  end

  // Request level only to the decoded slave
  assign req_o = (state_q == MST_REQ) ? tgt_q : '0;

  assign hold_id_o    = id_q;
  assign hold_addr_o  = addr_q;
  assign hold_len_o   = len_q;
  assign hold_size_o  = size_q;
  assign hold_burst_o = burst_q;

  // Local error beat unless data comes from the target slave
  always_comb begin
    r_id_o    = id_q;
    r_data_o  = '0;
    r_resp_o  = RESP_DECERR;
    r_last_o  = 1'b1;
    r_valid_o = (state_q == MST_DECERR);
    if (state_q == MST_DATA) begin
      for (int s = 0; s < N_SLV; s++) begin
        if (tgt_q[s]) begin
          r_id_o    = sl_r_id_i[s];
          r_data_o  = sl_r_data_i[s];
          r_resp_o  = sl_r_resp_i[s];
          r_last_o  = sl_r_last_i[s];
          r_valid_o = sl_r_valid_i[s];
        end
      end
    end
  end

endmodule

/* design/rd_slave_port.sv */
// Slave side read port that arbitrates the masters and steers R back by ID
`timescale 1ns/100ps

module rd_slave_port (
  input  logic                       axi_clk_i,
  input  logic                       rst_n_i,
  // Held AR requests from the master ports
  input  logic [xbar_pkg::N_MST-1:0] req_i,
  input  logic [axi_pkg::ID_W-1:0]   id_i    [xbar_pkg::N_MST],
  input  logic [axi_pkg::ADDR_W-1:0] addr_i  [xbar_pkg::N_MST],
  input  logic [axi_pkg::LEN_W-1:0]  len_i   [xbar_pkg::N_MST],
  input  logic [axi_pkg::SIZE_W-1:0] size_i  [xbar_pkg::N_MST],
  input  axi_pkg::axi_burst_e        burst_i [xbar_pkg::N_MST],
  input  logic [xbar_pkg::N_MST-1:0] r_ready_i,
  // AR to the slave
  output logic [axi_pkg::IDS_W-1:0]  s_ar_id_o,
  output logic [axi_pkg::ADDR_W-1:0] s_ar_addr_o,
  output logic [axi_pkg::LEN_W-1:0]  s_ar_len_o,
  output logic [axi_pkg::SIZE_W-1:0] s_ar_size_o,
  output axi_pkg::axi_burst_e        s_ar_burst_o,
  output logic                       s_ar_valid_o,
  input  logic                       s_ar_ready_i,
  // R from the slave
  input  logic [axi_pkg::IDS_W-1:0]  s_r_id_i,
  input  logic [axi_pkg::DATA_W-1:0] s_r_data_i,
  input  axi_pkg::axi_resp_e         s_r_resp_i,
  input  logic                       s_r_last_i,
  input  logic                       s_r_valid_i,
  output logic                       s_r_ready_o,
  // Back to the master ports
  output logic [xbar_pkg::N_MST-1:0] grant_done_o,
  output logic [axi_pkg::ID_W-1:0]   r_id_o   [xbar_pkg::N_MST],
  output logic [axi_pkg::DATA_W-1:0] r_data_o [xbar_pkg::N_MST],
  output axi_pkg::axi_resp_e         r_resp_o [xbar_pkg::N_MST],
  output logic [xbar_pkg::N_MST-1:0] r_last_o,
  output logic [xbar_pkg::N_MST-1:0] r_valid_o
);

  import axi_pkg::*;
  import xbar_pkg::*;

  logic busy_q;
  logic gnt_q;
  logic mst_sel;
  logic ar_hs;
  logic r_owner;

  // Master 0 wins when idle, grant locked while the AR waits on the slave
  assign mst_sel      = busy_q ? gnt_q : !req_i[0];
  assign s_ar_valid_o = |req_i;
  assign ar_hs        = s_ar_valid_o && s_ar_ready_i;

  always_ff @(posedge axi_clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      gnt_q  <= 1'b0;
    end else if (ar_hs) begin
      busy_q <= 1'b0;
    end else if (s_ar_valid_o) begin
      busy_q <= 1'b1;
      gnt_q  <= mst_sel;
    end
  end

  // Master index rides as the ID's top bit
  assign s_ar_id_o    = {mst_sel, id_i[mst_sel]};
  assign s_ar_addr_o  = addr_i[mst_sel];
  assign s_ar_len_o   = len_i[mst_sel];
  assign s_ar_size_o  = size_i[mst_sel];
  assign s_ar_burst_o = burst_i[mst_sel];

  assign r_owner     = s_r_id_i[IDS_W-1];
  assign s_r_ready_o = r_ready_i[r_owner];

  for (genvar m = 0; m < N_MST; m++) begin : g_mst
    assign grant_done_o[m] = ar_hs && (mst_sel == 1'(m));
    assign r_valid_o[m]    = s_r_valid_i && (r_owner == 1'(m));
    assign r_last_o[m]     = s_r_last_i;
    // trim the index bit on the way back
    assign r_id_o[m]       = s_r_id_i[ID_W-1:0];
    assign r_data_o[m]     = s_r_data_i;
    assign r_resp_o[m]     = s_r_resp_i;
  end

endmodule

/* design/axi_rd_xbar.sv */
// Two master by two slave AXI read interconnect built from port modules
`timescale 1ns/100ps

module axi_rd_xbar (
  input  logic                       axi_clk_i,
  input  logic                       rst_n_i,
  // M0
  input  logic [axi_pkg::ID_W-1:0]   m0_arid_i,
  input  logic [axi_pkg::ADDR_W-1:0] m0_araddr_i,
  input  logic [axi_pkg::LEN_W-1:0]  m0_arlen_i,
  input  logic [axi_pkg::SIZE_W-1:0] m0_arsize_i,
  input  axi_pkg::axi_burst_e        m0_arburst_i,
  input  logic                       m0_arvalid_i,
  output logic                       m0_arready_o,
  output logic [axi_pkg::ID_W-1:0]   m0_rid_o,
  output logic [axi_pkg::DATA_W-1:0] m0_rdata_o,
  output axi_pkg::axi_resp_e         m0_rresp_o,
  output logic                       m0_rlast_o,
  output logic                       m0_rvalid_o,
  input  logic                       m0_rready_i,
  // M1
  input  logic [axi_pkg::ID_W-1:0]   m1_arid_i,
  input  logic [axi_pkg::ADDR_W-1:0] m1_araddr_i,
  input  logic [axi_pkg::LEN_W-1:0]  m1_arlen_i,
  input  logic [axi_pkg::SIZE_W-1:0] m1_arsize_i,
  input  axi_pkg::axi_burst_e        m1_arburst_i,
  input  logic                       m1_arvalid_i,
  output logic                       m1_arready_o,
  output logic [axi_pkg::ID_W-1:0]   m1_rid_o,
  output logic [axi_pkg::DATA_W-1:0] m1_rdata_o,
  output axi_pkg::axi_resp_e         m1_rresp_o,
  output logic                       m1_rlast_o,
  output logic                       m1_rvalid_o,
  input  logic                       m1_rready_i,
  // S0
  output logic [axi_pkg::IDS_W-1:0]  s0_arid_o,
  output logic [axi_pkg::ADDR_W-1:0] s0_araddr_o,
  output logic [axi_pkg::LEN_W-1:0]  s0_arlen_o,
  output logic [axi_pkg::SIZE_W-1:0] s0_arsize_o,
  output axi_pkg::axi_burst_e        s0_arburst_o,
  output logic                       s0_arvalid_o,
  input  logic                       s0_arready_i,
  input  logic [axi_pkg::IDS_W-1:0]  s0_rid_i,
  input  logic [axi_pkg::DATA_W-1:0] s0_rdata_i,
  input  axi_pkg::axi_resp_e         s0_rresp_i,
  input  logic                       s0_rlast_i,
  input  logic                       s0_rvalid_i,
  output logic                       s0_rready_o,
  // S1
  output logic [axi_pkg::IDS_W-1:0]  s1_arid_o,
  output logic [axi_pkg::ADDR_W-1:0] s1_araddr_o,
  output logic [axi_pkg::LEN_W-1:0]  s1_arlen_o,
  output logic [axi_pkg::SIZE_W-1:0] s1_arsize_o,
  output axi_pkg::axi_burst_e        s1_arburst_o,
  output logic                       s1_arvalid_o,
  input  logic                       s1_arready_i,
  input  logic [axi_pkg::IDS_W-1:0]  s1_rid_i,
  input  logic [axi_pkg::DATA_W-1:0] s1_rdata_i,
  input  axi_pkg::axi_resp_e         s1_rresp_i,
  input  logic                       s1_rlast_i,
  input  logic                       s1_rvalid_i,
  output logic                       s1_rready_o
);

  import axi_pkg::*;
  import xbar_pkg::*;

  // Indexed by master, then slave
  logic [SLV_SEL_W-1:0] mst_req      [N_MST];
  logic [SLV_SEL_W-1:0] mst_gnt_done [N_MST];
  logic [ID_W-1:0]      mst_r_id     [N_MST][N_SLV];
  logic [DATA_W-1:0]    mst_r_data   [N_MST][N_SLV];
  axi_resp_e            mst_r_resp   [N_MST][N_SLV];
  logic [N_SLV-1:0]     mst_r_last   [N_MST];
  logic [N_SLV-1:0]     mst_r_valid  [N_MST];

  // Indexed by slave, then master
  logic [N_MST-1:0]     slv_req      [N_SLV];
  logic [N_MST-1:0]     slv_gnt_done [N_SLV];
  logic [ID_W-1:0]      slv_r_id     [N_SLV][N_MST];
  logic [DATA_W-1:0]    slv_r_data   [N_SLV][N_MST];
  axi_resp_e            slv_r_resp   [N_SLV][N_MST];
  logic [N_MST-1:0]     slv_r_last   [N_SLV];
  logic [N_MST-1:0]     slv_r_valid  [N_SLV];

  logic [ID_W-1:0]      hold_id    [N_MST];
  logic [ADDR_W-1:0]    hold_addr  [N_MST];
  logic [LEN_W-1:0]     hold_len   [N_MST];
  logic [SIZE_W-1:0]    hold_size  [N_MST];
  axi_burst_e           hold_burst [N_MST];

  for (genvar m = 0; m < N_MST; m++) begin : g_mst
    for (genvar s = 0; s < N_SLV; s++) begin : g_slv
      assign slv_req[s][m]      = mst_req[m][s];
      assign mst_gnt_done[m][s] = slv_gnt_done[s][m];
      assign mst_r_id[m][s]     = slv_r_id[s][m];
      assign mst_r_data[m][s]   = slv_r_data[s][m];
      assign mst_r_resp[m][s]   = slv_r_resp[s][m];
      assign mst_r_last[m][s]   = slv_r_last[s][m];
      assign mst_r_valid[m][s]  = slv_r_valid[s][m];
    end
  end

  rd_master_port u_mst0 (
    .axi_clk_i(axi_clk_i), .rst_n_i(rst_n_i),
    .ar_id_i(m0_arid_i), .ar_addr_i(m0_araddr_i), .ar_len_i(m0_arlen_i),
    .ar_size_i(m0_arsize_i), .ar_burst_i(m0_arburst_i), .ar_valid_i(m0_arvalid_i),
    .ar_ready_o(m0_arready_o),
    .r_id_o(m0_rid_o), .r_data_o(m0_rdata_o), .r_resp_o(m0_rresp_o),
    .r_last_o(m0_rlast_o), .r_valid_o(m0_rvalid_o), .r_ready_i(m0_rready_i),
    .req_o(mst_req[0]), .grant_done_i(mst_gnt_done[0]),
    .hold_id_o(hold_id[0]), .hold_addr_o(hold_addr[0]), .hold_len_o(hold_len[0]),
    .hold_size_o(hold_size[0]), .hold_burst_o(hold_burst[0]),
    .sl_r_id_i(mst_r_id[0]), .sl_r_data_i(mst_r_data[0]), .sl_r_resp_i(mst_r_resp[0]),
    .sl_r_last_i(mst_r_last[0]), .sl_r_valid_i(mst_r_valid[0])
  );

  rd_master_port u_mst1 (
    .axi_clk_i(axi_clk_i), .rst_n_i(rst_n_i),
    .ar_id_i(m1_arid_i), .ar_addr_i(m1_araddr_i), .ar_len_i(m1_arlen_i),
    .ar_size_i(m1_arsize_i), .ar_burst_i(m1_arburst_i), .ar_valid_i(m1_arvalid_i),
    .ar_ready_o(m1_arready_o),
    .r_id_o(m1_rid_o), .r_data_o(m1_rdata_o), .r_resp_o(m1_rresp_o),
    .r_last_o(m1_rlast_o), .r_valid_o(m1_rvalid_o), .r_ready_i(m1_rready_i),
    .req_o(mst_req[1]), .grant_done_i(mst_gnt_done[1]),
    .hold_id_o(hold_id[1]), .hold_addr_o(hold_addr[1]), .hold_len_o(hold_len[1]),
    .hold_size_o(hold_size[1]), .hold_burst_o(hold_burst[1]),
    .sl_r_id_i(mst_r_id[1]), .sl_r_data_i(mst_r_data[1]), .sl_r_resp_i(mst_r_resp[1]),
    .sl_r_last_i(mst_r_last[1]), .sl_r_valid_i(mst_r_valid[1])
  );

  rd_slave_port u_slv0 (
    .axi_clk_i(axi_clk_i), .rst_n_i(rst_n_i),
    .req_i(slv_req[0]), .id_i(hold_id), .addr_i(hold_addr), .len_i(hold_len),
    .size_i(hold_size), .burst_i(hold_burst), .r_ready_i({m1_rready_i, m0_rready_i}),
    .s_ar_id_o(s0_arid_o), .s_ar_addr_o(s0_araddr_o), .s_ar_len_o(s0_arlen_o),
    .s_ar_size_o(s0_arsize_o), .s_ar_burst_o(s0_arburst_o),
    .s_ar_valid_o(s0_arvalid_o), .s_ar_ready_i(s0_arready_i),
    .s_r_id_i(s0_rid_i), .s_r_data_i(s0_rdata_i), .s_r_resp_i(s0_rresp_i),
    .s_r_last_i(s0_rlast_i), .s_r_valid_i(s0_rvalid_i), .s_r_ready_o(s0_rready_o),
    .grant_done_o(slv_gnt_done[0]),
    .r_id_o(slv_r_id[0]), .r_data_o(slv_r_data[0]), .r_resp_o(slv_r_resp[0]),
    .r_last_o(slv_r_last[0]), .r_valid_o(slv_r_valid[0])
  );

  rd_slave_port u_slv1 (
    .axi_clk_i(axi_clk_i), .rst_n_i(rst_n_i),
    .req_i(slv_req[1]), .id_i(hold_id), .addr_i(hold_addr), .len_i(hold_len),
    .size_i(hold_size), .burst_i(hold_burst), .r_ready_i({m1_rready_i, m0_rready_i}),
    .s_ar_id_o(s1_arid_o), .s_ar_addr_o(s1_araddr_o), .s_ar_len_o(s1_arlen_o),
    .s_ar_size_o(s1_arsize_o), .s_ar_burst_o(s1_arburst_o),
    .s_ar_valid_o(s1_arvalid_o), .s_ar_ready_i(s1_arready_i),
    .s_r_id_i(s1_rid_i), .s_r_data_i(s1_rdata_i), .s_r_resp_i(s1_rresp_i),
    .s_r_last_i(s1_rlast_i), .s_r_valid_i(s1_rvalid_i), .s_r_ready_o(s1_rready_o),
    .grant_done_o(slv_gnt_done[1]),
    .r_id_o(slv_r_id[1]), .r_data_o(slv_r_data[1]), .r_resp_o(slv_r_resp[1]),
    .r_last_o(slv_r_last[1]), .r_valid_o(slv_r_valid[1])
  );

endmodule

/* bench/tb_clock.sv */
// Free running testbench clock with a 10 ns period
`timescale 1ns/100ps

module tb_clock (
  output logic clk_o
);

  localparam int HALF_PERIOD = 5;

  initial begin
    clk_o = 1'b0;
    forever begin
      #HALF_PERIOD clk_o = ~clk_o;
    end
  end

endmodule

/* bench/tb_slave_model.sv */
// AXI read slave model returning address-derived beats after random delays
`timescale 1ns/100ps

module tb_slave_model #(
  parameter logic [axi_pkg::ADDR_W-1:0] BASE_ADDR = '0
) (
  input  logic                       axi_clk_i,
  input  logic                       rst_n_i,
  input  logic [axi_pkg::IDS_W-1:0]  arid_i,
  input  logic [axi_pkg::ADDR_W-1:0] araddr_i,
  input  logic [axi_pkg::LEN_W-1:0]  arlen_i,
  input  logic [axi_pkg::SIZE_W-1:0] arsize_i,
  input  axi_pkg::axi_burst_e        arburst_i,
  input  logic                       arvalid_i,
  output logic                       arready_o,
  output logic [axi_pkg::IDS_W-1:0]  rid_o,
  output logic [axi_pkg::DATA_W-1:0] rdata_o,
  output axi_pkg::axi_resp_e         rresp_o,
  output logic                       rlast_o,
  output logic                       rvalid_o,
  input  logic                       rready_i
);

  import axi_pkg::*;
  import xbar_pkg::*;

  logic              busy_q;
  logic [IDS_W-1:0]  id_q;
  logic [ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]  len_q;
  logic [LEN_W-1:0]  beat_q;
  logic [1:0]        gap_q;
  axi_resp_e         resp_q;

  always @(posedge axi_clk_i) begin
    if (!rst_n_i) begin
      busy_q    <= 1'b0;
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      rlast_o   <= 1'b0;
      rid_o     <= '0;
      rdata_o   <= '0;
      rresp_o   <= RESP_OKAY;
    end else if (!busy_q) begin
      if (arvalid_i && arready_o) begin
        busy_q    <= 1'b1;
        arready_o <= 1'b0;
        id_q      <= arid_i;
        addr_q    <= araddr_i;
        len_q     <= arlen_i;
        beat_q    <= '0;
        gap_q     <= 2'($urandom_range(0, 3));
        // Misrouted, narrow or non-INCR requests get SLVERR
        resp_q    <= ((araddr_i - BASE_ADDR) < SLV_SPAN && arburst_i == BURST_INCR &&
                      arsize_i == SIZE_W'($clog2(DATA_W / 8))) ? RESP_OKAY : RESP_SLVERR;
      end else begin
        arready_o <= 1'($urandom_range(0, 1));
      end
    end else if (rvalid_o) begin
      if (rready_i) begin
        rvalid_o <= 1'b0;
        busy_q   <= !rlast_o;
        beat_q   <= beat_q + LEN_W'(1);
        gap_q    <= 2'($urandom_range(0, 3));
      end
    end else if (gap_q != 2'd0) begin
      gap_q <= gap_q - 2'd1;
    end else begin
      rvalid_o <= 1'b1;
      rid_o    <= id_q;
      rdata_o  <= addr_q + (ADDR_W'(beat_q) << 2);
      rresp_o  <= resp_q;
      rlast_o  <= (beat_q == len_q);
    end
  end

endmodule

/* bench/xbar_asserts.sv */
// Bound AR and R handshake checks on the read interconnect top level
`timescale 1ns/100ps

module xbar_asserts (
  input logic                       axi_clk_i,
  input logic                       rst_n_i,
  input logic                       s0_arvalid_i,
  input logic                       s0_arready_i,
  input logic [axi_pkg::ADDR_W-1:0] s0_araddr_i,
  input logic                       s1_arvalid_i,
  input logic                       s1_arready_i,
  input logic [axi_pkg::ADDR_W-1:0] s1_araddr_i,
  input logic                       m0_rvalid_i,
  input logic                       m0_rready_i,
  input logic [axi_pkg::DATA_W-1:0] m0_rdata_i,
  input logic                       m1_rvalid_i,
  input logic                       m1_rready_i,
  input logic [axi_pkg::DATA_W-1:0] m1_rdata_i
);

  int fail_cnt = 0;

  s0_ar_hold: assert property (@(posedge axi_clk_i) disable iff (!rst_n_i)
    s0_arvalid_i && !s0_arready_i |=> s0_arvalid_i && $stable(s0_araddr_i))
    else begin
      $error("s0 arvalid or araddr changed before arready");
      fail_cnt++;
    end

  s1_ar_hold: assert property (@(posedge axi_clk_i) disable iff (!rst_n_i)
    s1_arvalid_i && !s1_arready_i |=> s1_arvalid_i && $stable(s1_araddr_i))
    else begin
      $error("s1 arvalid or araddr changed before arready");
      fail_cnt++;
    end

  m0_r_hold: assert property (@(posedge axi_clk_i) disable iff (!rst_n_i)
    m0_rvalid_i && !m0_rready_i |=> m0_rvalid_i && $stable(m0_rdata_i))
    else begin
      $error("m0 rvalid or rdata changed while rready was low");
      fail_cnt++;
    end

  m1_r_hold: assert property (@(posedge axi_clk_i) disable iff (!rst_n_i)
    m1_rvalid_i && !m1_rready_i |=> m1_rvalid_i && $stable(m1_rdata_i))
    else begin
      $error("m1 rvalid or rdata changed while rready was low");
      fail_cnt++;
    end

  // Nothing is pending right after a reset cycle
  ar_quiet_after_reset: assert property (@(posedge axi_clk_i)
    !rst_n_i |=> !s0_arvalid_i && !s1_arvalid_i)
    else begin
      $error("slave arvalid high in the cycle after reset");
      fail_cnt++;
    end

endmodule

bind axi_rd_xbar xbar_asserts xbar_asserts_i (
  .axi_clk_i(axi_clk_i), .rst_n_i(rst_n_i),
  .s0_arvalid_i(s0_arvalid_o), .s0_arready_i(s0_arready_i), .s0_araddr_i(s0_araddr_o),
  .s1_arvalid_i(s1_arvalid_o), .s1_arready_i(s1_arready_i), .s1_araddr_i(s1_araddr_o),
  .m0_rvalid_i(m0_rvalid_o), .m0_rready_i(m0_rready_i), .m0_rdata_i(m0_rdata_o),
  .m1_rvalid_i(m1_rvalid_o), .m1_rready_i(m1_rready_i), .m1_rdata_i(m1_rdata_o)
);

/* bench/tb_top.sv */
// Directed testbench for the two master, two slave AXI read interconnect
`timescale 1ns/100ps

module tb_top;

  import axi_pkg::*;
  import xbar_pkg::*;

  localparam logic [31:0] SEED       = 32'h67b8_b470;
  localparam int          AR_TIMEOUT = 200;
  localparam int          R_TIMEOUT  = 500;

  logic axi_clk;
  logic rst_n;

  // Master side, indexed by master
  logic [ID_W-1:0]   arid    [2];
  logic [ADDR_W-1:0] araddr  [2];
  logic [LEN_W-1:0]  arlen   [2];
  logic [SIZE_W-1:0] arsize  [2];
  axi_burst_e        arburst [2];
  logic              arvalid [2];
  logic              arready [2];
  logic [ID_W-1:0]   rid     [2];
  logic [DATA_W-1:0] rdata   [2];
  axi_resp_e         rresp   [2];
  logic              rlast   [2];
  logic              rvalid  [2];
  logic              rready  [2];

  // Slave side, indexed by slave
  logic [IDS_W-1:0]  s_arid    [2];
  logic [ADDR_W-1:0] s_araddr  [2];
  logic [LEN_W-1:0]  s_arlen   [2];
  logic [SIZE_W-1:0] s_arsize  [2];
  axi_burst_e        s_arburst [2];
  logic              s_arvalid [2];
  logic              s_arready [2];
  logic [IDS_W-1:0]  s_rid     [2];
  logic [DATA_W-1:0] s_rdata   [2];
  axi_resp_e         s_rresp   [2];
  logic              s_rlast   [2];
  logic              s_rvalid  [2];
  logic              s_rready  [2];

  time first_beat_t [2];
  int  slv_ar_cnt;

  tb_clock clk_gen_i (.clk_o(axi_clk));

  axi_rd_xbar axi_rd_xbar_i (
    .axi_clk_i(axi_clk), .rst_n_i(rst_n),
    .m0_arid_i(arid[0]), .m0_araddr_i(araddr[0]), .m0_arlen_i(arlen[0]),
    .m0_arsize_i(arsize[0]), .m0_arburst_i(arburst[0]), .m0_arvalid_i(arvalid[0]),
    .m0_arready_o(arready[0]), .m0_rid_o(rid[0]), .m0_rdata_o(rdata[0]),
    .m0_rresp_o(rresp[0]), .m0_rlast_o(rlast[0]), .m0_rvalid_o(rvalid[0]),
    .m0_rready_i(rready[0]),
    .m1_arid_i(arid[1]), .m1_araddr_i(araddr[1]), .m1_arlen_i(arlen[1]),
    .m1_arsize_i(arsize[1]), .m1_arburst_i(arburst[1]), .m1_arvalid_i(arvalid[1]),
    .m1_arready_o(arready[1]), .m1_rid_o(rid[1]), .m1_rdata_o(rdata[1]),
    .m1_rresp_o(rresp[1]), .m1_rlast_o(rlast[1]), .m1_rvalid_o(rvalid[1]),
    .m1_rready_i(rready[1]),
    .s0_arid_o(s_arid[0]), .s0_araddr_o(s_araddr[0]), .s0_arlen_o(s_arlen[0]),
    .s0_arsize_o(s_arsize[0]), .s0_arburst_o(s_arburst[0]), .s0_arvalid_o(s_arvalid[0]),
    .s0_arready_i(s_arready[0]), .s0_rid_i(s_rid[0]), .s0_rdata_i(s_rdata[0]),
    .s0_rresp_i(s_rresp[0]), .s0_rlast_i(s_rlast[0]), .s0_rvalid_i(s_rvalid[0]),
    .s0_rready_o(s_rready[0]),
    .s1_arid_o(s_arid[1]), .s1_araddr_o(s_araddr[1]), .s1_arlen_o(s_arlen[1]),
    .s1_arsize_o(s_arsize[1]), .s1_arburst_o(s_arburst[1]), .s1_arvalid_o(s_arvalid[1]),
    .s1_arready_i(s_arready[1]), .s1_rid_i(s_rid[1]), .s1_rdata_i(s_rdata[1]),
    .s1_rresp_i(s_rresp[1]), .s1_rlast_i(s_rlast[1]), .s1_rvalid_i(s_rvalid[1]),
    .s1_rready_o(s_rready[1])
  );

  tb_slave_model #(.BASE_ADDR(S0_BASE)) s0_model_i (
    .axi_clk_i(axi_clk), .rst_n_i(rst_n),
    .arid_i(s_arid[0]), .araddr_i(s_araddr[0]), .arlen_i(s_arlen[0]),
    .arsize_i(s_arsize[0]),
    .arburst_i(s_arburst[0]), .arvalid_i(s_arvalid[0]), .arready_o(s_arready[0]),
    .rid_o(s_rid[0]), .rdata_o(s_rdata[0]), .rresp_o(s_rresp[0]),
    .rlast_o(s_rlast[0]), .rvalid_o(s_rvalid[0]), .rready_i(s_rready[0])
  );

  tb_slave_model #(.BASE_ADDR(S1_BASE)) s1_model_i (
    .axi_clk_i(axi_clk), .rst_n_i(rst_n),
    .arid_i(s_arid[1]), .araddr_i(s_araddr[1]), .arlen_i(s_arlen[1]),
    .arsize_i(s_arsize[1]),
    .arburst_i(s_arburst[1]), .arvalid_i(s_arvalid[1]), .arready_o(s_arready[1]),
    .rid_o(s_rid[1]), .rdata_o(s_rdata[1]), .rresp_o(s_rresp[1]),
    .rlast_o(s_rlast[1]), .rvalid_o(s_rvalid[1]), .rready_i(s_rready[1])
  );

  // Cycles with any slave-side AR request
  always @(posedge axi_clk) begin
    if (!rst_n) begin
      slv_ar_cnt <= 0;
    end else if (s_arvalid[0] || s_arvalid[1]) begin
      slv_ar_cnt <= slv_ar_cnt + 1;
    end
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_id(input string name, input logic [ID_W-1:0] got,
                          input logic [ID_W-1:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_e got, input axi_resp_e exp);
    if (got !== exp) begin
      fail_now($sformatf("mismatch at %0t: %s got %s expected %s", $time, name,
                         got.name(), exp.name()));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  function automatic logic next_rready(input logic bp);
    return bp ? 1'($urandom_range(0, 1)) : 1'b1;
  endfunction

  task automatic send_ar(input int m, input logic [ID_W-1:0] id,
                         input logic [ADDR_W-1:0] addr, input logic [LEN_W-1:0] len);
    int waited;
    @(posedge axi_clk);
    arid[m]    <= id;
    araddr[m]  <= addr;
    arlen[m]   <= len;
    arvalid[m] <= 1'b1;
    waited = 0;
    do begin
      @(posedge axi_clk);
      waited++;
      if (waited > AR_TIMEOUT) begin
        fail_now($sformatf("master %0d AR was not accepted in time", m));
      end
    end while (!arready[m]);
    arvalid[m] <= 1'b0;
  endtask

  // Beat k carries addr plus 4k, or zero for a decode error
  task automatic collect_r(input int m, input logic [ID_W-1:0] id,
                           input logic [ADDR_W-1:0] addr, input logic [LEN_W-1:0] len,
                           input axi_resp_e exp_resp, input logic bp);
    int                beat;
    int                waited;
    logic              held;
    logic [DATA_W-1:0] held_dat;
    logic [DATA_W-1:0] exp_dat;
    beat = 0;
    waited = 0;
    held = 1'b0;
    held_dat = '0;
    rready[m] <= next_rready(bp);
    while (beat <= int'(len)) begin
      @(posedge axi_clk);
      if (held && !rvalid[m]) begin
        fail_now($sformatf("master %0d rvalid dropped while rready was low", m));
      end
      if (held) begin
        check_data($sformatf("m%0d_rdata held", m), rdata[m], held_dat);
      end
      if (rvalid[m] && rready[m]) begin
        exp_dat = (exp_resp == RESP_DECERR) ? '0 : addr + DATA_W'(beat * 4);
        check_data($sformatf("m%0d_rdata", m), rdata[m], exp_dat);
        check_id($sformatf("m%0d_rid", m), rid[m], id);
        check_resp($sformatf("m%0d_rresp", m), rresp[m], exp_resp);
        check_flag($sformatf("m%0d_rlast", m), rlast[m], beat == int'(len));
        if (beat == 0) begin
          first_beat_t[m] = $time;
        end
        beat++;
        held = 1'b0;
        waited = 0;
      end else begin
        held = rvalid[m];
        held_dat = rdata[m];
        waited++;
        if (waited > R_TIMEOUT) begin
          fail_now($sformatf("master %0d timed out waiting for read data", m));
        end
      end
      rready[m] <= (beat <= int'(len)) ? next_rready(bp) : 1'b0;
    end
  endtask

  task automatic read_txn(input int m, input logic [ID_W-1:0] id,
                          input logic [ADDR_W-1:0] addr, input logic [LEN_W-1:0] len,
                          input axi_resp_e exp_resp, input logic bp);
    send_ar(m, id, addr, len);
    collect_r(m, id, addr, len, exp_resp, bp);
  endtask

  task automatic reset_state();
    @(posedge axi_clk);
    for (int m = 0; m < 2; m++) begin
      check_flag($sformatf("m%0d_arready", m), arready[m], 1'b1);
      check_flag($sformatf("m%0d_rvalid", m), rvalid[m], 1'b0);
    end
  endtask

  task automatic single_read();
    read_txn(0, 4'h3, S0_BASE + 32'h0000_0100, 4'd0, RESP_OKAY, 1'b0);
    read_txn(0, 4'h5, S1_BASE + 32'h0000_0040, 4'd0, RESP_OKAY, 1'b0);
  endtask

  task automatic burst_read();
    read_txn(1, 4'ha, S1_BASE + 32'h0000_0200, 4'd3, RESP_OKAY, 1'b1);
  endtask

  task automatic contention();
    fork
      read_txn(0, 4'h1, S0_BASE + 32'h0000_0300, 4'd1, RESP_OKAY, 1'b0);
      read_txn(1, 4'h2, S0_BASE + 32'h0000_0400, 4'd1, RESP_OKAY, 1'b0);
    join
    if (first_beat_t[0] >= first_beat_t[1]) begin
      fail_now("master 1 data arrived before master 0 data on a shared slave");
    end
  endtask

  task automatic parallel_reads();
    fork
      read_txn(0, 4'h6, S0_BASE + 32'h0000_0800, 4'd2, RESP_OKAY, 1'b1);
      read_txn(1, 4'h9, S1_BASE + 32'h0000_0a00, 4'd2, RESP_OKAY, 1'b0);
    join
  endtask

  task automatic decode_error();
    int ar_cycles_start;
    ar_cycles_start = slv_ar_cnt;
    read_txn(0, 4'h7, S1_BASE + SLV_SPAN, 4'd0, RESP_DECERR, 1'b0);
    read_txn(1, 4'hc, 32'hffff_fff0, 4'd0, RESP_DECERR, 1'b1);
    if (slv_ar_cnt != ar_cycles_start) begin
      fail_now("a slave saw arvalid during a decode error read");
    end
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n <= 1'b0;
    for (int m = 0; m < 2; m++) begin
      arid[m]    <= '0;
      araddr[m]  <= '0;
      arlen[m]   <= '0;
      arsize[m]  <= 3'd2;
      arburst[m] <= BURST_INCR;
      arvalid[m] <= 1'b0;
      rready[m]  <= 1'b0;
    end
    repeat (8) @(posedge axi_clk);
    rst_n <= 1'b1;

    reset_state();
    single_read();
    burst_read();
    contention();
    parallel_reads();
    decode_error();
    repeat (4) @(posedge axi_clk);

    if (axi_rd_xbar_i.xbar_asserts_i.fail_cnt == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1, "bound assertions reported errors");
    end
  end

endmodule

/* vlog.f */
design/axi_pkg.sv
design/xbar_pkg.sv
design/rd_master_port.sv
design/rd_slave_port.sv
design/axi_rd_xbar.sv
bench/tb_clock.sv
bench/tb_slave_model.sv
bench/xbar_asserts.sv
bench/tb_top.sv

/* run.sh */
#!/bin/sh
# Build and run the AXI read interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f vlog.f --top-module tb_top -Mdir obj_dir -o tb_top_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/tb_top_sim)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^Test completed successfully$"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
